// ==== list.f ====
+incdir+rtl
rtl/rob_except_pkg.sv
rtl/rob_types_pkg.sv
rtl/lsb_select.sv
rtl/rob_disp_intake.sv
rtl/rob_entry.sv
rtl/rob_commit.sv
rtl/rob_top.sv
bench/rob_asserts.sv
bench/rob_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f list.f --top-module rob_tb -o sim_rob

# Log decides the result
./obj_dir/sim_rob > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  exit 0
fi
echo "run.sh: pass message not found in sim.log"
exit 1

// ==== bench/rob_tb.sv ====
`include "rob_consts.svh"

module rob_tb
  import rob_except_pkg::*;
  import rob_types_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  logic                      clk;
  logic                      reset_n;
  disp_grp_t                 disp;
  done_rpt_t                 done_rpt [`ROB_DONE_BUS];
  logic [`ROB_CMT_ID_W-1:0]  new_cmt_id;
  commit_blk_t               commit;
  credit_ret_t               credit_ret;

  logic [31:0]               lfsr_state;
  int                        credits;
  logic [`ROB_CMT_ID_W-1:0]  model_id;    // Id the next accepted group gets
  commit_blk_t               exp_q [$];   // Expected commits oldest first
  done_rpt_t                 rpt_q [$];   // Reports waiting to be sent

  // Per-lane outcome of the group about to be dispatched
  logic [`ROB_DISP_SIZE-1:0] lane_exc;
  logic [`ROB_DISP_SIZE-1:0] lane_mis;
  except_cause_t             lane_cause [`ROB_DISP_SIZE];
  logic [`ROB_VADDR_W-1:0]   lane_tgt [`ROB_DISP_SIZE];

  rob_top DUT (
    .i_clk        (clk),
    .i_reset_n    (reset_n),
    .i_disp       (disp),
    .i_done_rpt   (done_rpt),
    .o_new_cmt_id (new_cmt_id),
    .o_commit     (commit),
    .o_credit_ret (credit_ret)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] want);
    assert (got === want) else
      report_failure($sformatf("error: %s = 0x%h, expected 0x%h", name, got, want));
  endtask

  function automatic logic rand_bit();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
    end
    return lsb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = rand_bit();
    end
    return v;
  endfunction

  function automatic logic [`ROB_DISP_SIZE-1:0] random_mask();
    logic [31:0] v;
    v = rand_bits(`ROB_DISP_SIZE);
    return (v[3:0] == 4'b0000) ? 4'b0001 : v[3:0];
  endfunction

  // Environment calls and returns retire the reporting lane
  function automatic logic lane_survives(input except_cause_t cause);
    return (cause == ECALL_U) || (cause == ECALL_M) || (cause == MRET) || (cause == SILENT_FLUSH);
  endfunction

  function automatic commit_blk_t expect_live(input logic [`ROB_CMT_ID_W-1:0] id,
                                              input logic [31:0] pc, input logic [3:0] mask);
    commit_blk_t e;
    int          redir;
    e = '0;
    redir = -1;
    e.commit = 1'b1;
    e.cmt_id = id;
    e.grp_id = mask;
    for (int l = `ROB_DISP_SIZE - 1; l >= 0; l--) begin
      if (mask[l] && (lane_exc[l] || lane_mis[l])) redir = l;  // Lowest wins
    end
    if (redir >= 0) begin
      e.upd_pc_valid = 1'b1;
      for (int l = redir + 1; l < `ROB_DISP_SIZE; l++) begin
        e.dead_id[l] = mask[l];
      end
      if (lane_exc[redir]) begin
        e.except_valid[redir] = 1'b1;
        e.except_cause = lane_cause[redir];
        e.epc = pc + 32'(4 * redir);
        if (!lane_survives(lane_cause[redir])) e.dead_id[redir] = 1'b1;
      end else begin
        e.upd_pc_vaddr = lane_tgt[redir];
      end
    end
    return e;
  endfunction

  function automatic commit_blk_t as_killed(input commit_blk_t live);
    commit_blk_t k;
    k = '0;
    k.commit   = 1'b1;
    k.cmt_id   = live.cmt_id;
    k.grp_id   = live.grp_id;
    k.dead_id  = live.grp_id;
    k.all_dead = 1'b1;
    return k;
  endfunction

  task automatic clear_outcomes();
    lane_exc = '0;
    lane_mis = '0;
    for (int l = 0; l < `ROB_DISP_SIZE; l++) begin
      lane_cause[l] = INST_MISALIGN;
      lane_tgt[l]   = '0;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic dispatch_group(input logic [31:0] pc, input logic [3:0] mask, input bit send_rpt);
    done_rpt_t r;
    assert (credits > 0) else report_failure("dispatch attempted with no credit left");
    check_field("o_new_cmt_id", 32'(new_cmt_id), 32'(model_id));
    disp.valid       = 1'b1;
    disp.pc_addr     = pc;
    disp.lane_valid  = mask;
    disp.br_included = |lane_mis;
    exp_q.push_back(expect_live(model_id, pc, mask));
    if (send_rpt) begin
      for (int l = 0; l < `ROB_DISP_SIZE; l++) begin
        if (mask[l]) begin
          r = '0;
          r.valid        = 1'b1;
          r.cmt_id       = model_id;
          r.grp_id[l]    = 1'b1;
          r.except_valid = lane_exc[l];
          r.except_cause = lane_cause[l];
          r.br_mispred   = lane_mis[l];
          r.br_target    = lane_tgt[l];
          rpt_q.push_back(r);
        end
      end
    end
    credits  = credits - 1;
    model_id = model_id + 4'd1;
    next_cycle();
    disp.valid = 1'b0;
  endtask

  // Group sent while the head flushes and never stored
  task automatic drop_dispatch(input logic [31:0] pc, input logic [3:0] mask);
    assert (credits > 0) else report_failure("dispatch attempted with no credit left");
    disp.valid      = 1'b1;
    disp.pc_addr    = pc;
    disp.lane_valid = mask;
    credits = credits - 1;
    next_cycle();
    disp.valid = 1'b0;
    check_field("o_new_cmt_id", 32'(new_cmt_id), 32'(model_id));
  endtask

  task automatic send_reports();
    done_rpt_t tmp;
    int        j;
    logic      b;
    for (int i = rpt_q.size() - 1; i > 0; i--) begin  // Shuffle
      j = int'(rand_bits(8)) % (i + 1);
      tmp = rpt_q[i];
      rpt_q[i] = rpt_q[j];
      rpt_q[j] = tmp;
    end
    while (rpt_q.size() != 0) begin
      b = rand_bit();
      done_rpt[b] = rpt_q.pop_front();
      if (rpt_q.size() != 0 && rand_bit()) done_rpt[!b] = rpt_q.pop_front();
      next_cycle();
      done_rpt[0] = '0;
      done_rpt[1] = '0;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || credits != `ROB_ENTRY_SIZE) && n < 200) begin
      next_cycle();
      n++;
    end
    assert (exp_q.size() == 0) else report_failure("timed out waiting for groups to commit");
    check_field("credits", 32'(credits), 32'(`ROB_ENTRY_SIZE));
  endtask

  // Commit and credit monitor sampled mid-cycle
  always @(negedge clk) begin : monitor
    commit_blk_t want;
    if (reset_n) begin
      if (credit_ret.valid) credits = credits + int'(credit_ret.count);
      if (commit.commit) begin
        assert (exp_q.size() != 0) else report_failure("a group committed with none in flight");
        want = exp_q.pop_front();
        check_field("o_commit.cmt_id", 32'(commit.cmt_id), 32'(want.cmt_id));
        check_field("o_commit.grp_id", 32'(commit.grp_id), 32'(want.grp_id));
        check_field("o_commit.all_dead", 32'(commit.all_dead), 32'(want.all_dead));
        check_field("o_commit.upd_pc_valid", 32'(commit.upd_pc_valid), 32'(want.upd_pc_valid));
        check_field("o_commit.except_valid", 32'(commit.except_valid), 32'(want.except_valid));
        check_field("o_commit.dead_id", 32'(commit.dead_id), 32'(want.dead_id));
        if (want.upd_pc_valid && want.except_valid == '0) begin
          check_field("o_commit.upd_pc_vaddr", commit.upd_pc_vaddr, want.upd_pc_vaddr);
        end
        if (want.except_valid != '0) begin
          check_field("o_commit.except_cause", 32'(commit.except_cause), 32'(want.except_cause));
          check_field("o_commit.epc", commit.epc, want.epc);
        end
        if (want.upd_pc_valid && !want.all_dead) begin
          for (int i = 0; i < exp_q.size(); i++) exp_q[i] = as_killed(exp_q[i]);  // Younger die
        end
      end
    end
  end

  task automatic in_order_commit();
    clear_outcomes();
    for (int g = 0; g < 8; g++) dispatch_group(32'h0000_1000 + 32'(g * 16), random_mask(), 1'b1);
    send_reports();
    wait_drain();
  endtask

  task automatic credit_accounting();
    check_field("o_credit_ret.valid", 32'(credit_ret.valid), 32'd0);  // No return pending
    clear_outcomes();
    for (int g = 0; g < 8; g++) dispatch_group(32'h0000_2000 + 32'(g * 16), random_mask(), 1'b1);
    check_field("credits", 32'(credits), 32'd0);
    send_reports();
    wait_drain();
  endtask

  task automatic mispredict_flush();
    clear_outcomes();
    lane_mis[1] = 1'b1;
    lane_tgt[1] = 32'h8000_1230;
    dispatch_group(32'h0000_3000, random_mask() | 4'b0010, 1'b1);
    clear_outcomes();
    for (int g = 0; g < 3; g++) dispatch_group(32'h0000_3010 + 32'(g * 16), random_mask(), 1'b0);
    send_reports();
    wait_drain();
  endtask

  task automatic faulting_exception();
    clear_outcomes();
    lane_exc[2]   = 1'b1;
    lane_cause[2] = ILLEGAL_INST;
    dispatch_group(32'h0000_4000, random_mask() | 4'b0100, 1'b1);
    send_reports();
    wait_drain();
    lane_mis[1] = 1'b1;  // Lower mispredict takes priority
    lane_tgt[1] = 32'h8000_4440;
    dispatch_group(32'h0000_4100, random_mask() | 4'b0110, 1'b1);
    send_reports();
    wait_drain();
  endtask

  task automatic active_exception();
    clear_outcomes();
    lane_exc[0]   = 1'b1;
    lane_cause[0] = ECALL_M;
    dispatch_group(32'h0000_5000, random_mask() | 4'b0001, 1'b1);
    send_reports();
    wait_drain();
  endtask

  task automatic dispatch_in_flush();
    clear_outcomes();
    lane_mis[0] = 1'b1;
    lane_tgt[0] = 32'h8000_6000;
    dispatch_group(32'h0000_6000, random_mask() | 4'b0001, 1'b1);
    clear_outcomes();
    send_reports();
    assert (commit.commit && commit.upd_pc_valid) else
      report_failure("head group is not flushing in the cycle of the extra dispatch");
    drop_dispatch(32'h0000_6010, 4'b1111);
    wait_drain();
  endtask

  initial begin
    lfsr_state = 32'd81091;
    credits    = `ROB_ENTRY_SIZE;
    model_id   = '0;
    reset_n    = 1'b0;
    disp       = '0;
    done_rpt[0] = '0;
    done_rpt[1] = '0;
    clear_outcomes();
    repeat (5) @(posedge clk);
    #1;
    reset_n = 1'b1;
    next_cycle();

    in_order_commit();
    credit_accounting();
    mispredict_flush();
    faulting_exception();
    active_exception();
    dispatch_in_flush();

    if (exp_q.size() == 0 && credits == `ROB_ENTRY_SIZE) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      report_failure("model still holds groups or missing credits at the end");
    end
  end

endmodule

// ==== bench/rob_asserts.sv ====
`include "rob_consts.svh"

module rob_asserts
  import rob_types_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_reset_n,
  input  disp_grp_t    i_disp,
  input  commit_blk_t  i_commit,
  input  credit_ret_t  i_credit_ret
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CW = `ROB_ENTRY_W + 1;

  logic [CW-1:0] r_credits;  // Dispatcher credit count as seen on the ports

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_credits <= CW'(`ROB_ENTRY_SIZE);
    end else begin
      r_credits <= r_credits - CW'(i_disp.valid)
                 + (i_credit_ret.valid ? CW'(i_credit_ret.count) : CW'(0));
    end
  end

  a_credit_held: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_disp.valid |-> (r_credits != '0))
    else $error("dispatch issued while no credit was held");

  // Returns never exceed what the dispatcher spent
  a_ret_count: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_credit_ret.count <= 2'd2) && (r_credits <= CW'(`ROB_ENTRY_SIZE)))
    else $error("credit return count above two or credits above the entry count");

  // Drained groups never redirect fetch
  a_dead_no_redir: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_commit.all_dead |-> !i_commit.upd_pc_valid)
    else $error("all-dead commit carries a pc update");

endmodule

bind rob_top rob_asserts u_rob_asserts (
  .i_clk        (i_clk),
  .i_reset_n    (i_reset_n),
  .i_disp       (i_disp),
  .i_commit     (o_commit),
  .i_credit_ret (o_credit_ret)
);

// ==== rtl/rob_top.sv ====
`include "rob_consts.svh"

module rob_top
  import rob_types_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_reset_n,

  input  disp_grp_t                 i_disp,
  input  done_rpt_t                 i_done_rpt [`ROB_DONE_BUS],

  output logic [`ROB_CMT_ID_W-1:0]  o_new_cmt_id,
  output commit_blk_t               o_commit,
  output credit_ret_t               o_credit_ret
);

  logic [`ROB_ENTRY_SIZE-1:0]  w_load_oh;
  disp_grp_t                   w_load_grp;
  logic [`ROB_ENTRY_SIZE-1:0]  w_finish_oh;
  logic                        w_kill;
  logic                        w_flush;
  rob_entry_t                  w_entries [`ROB_ENTRY_SIZE];
  logic [`ROB_ENTRY_SIZE-1:0]  w_all_done;

  rob_disp_intake u_intake (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp       (i_disp),
    .i_flush      (w_flush),
    .i_commit     (o_commit.commit),
    .o_load_oh    (w_load_oh),
    .o_load_grp   (w_load_grp),
    .o_new_cmt_id (o_new_cmt_id),
    .o_credit_ret (o_credit_ret)
  );

  for (genvar e = 0; e < `ROB_ENTRY_SIZE; e++) begin : g_entry
    logic [`ROB_CMT_ID_W-1:0] w_cmt_id;

    // Entries behind the in-pointer were filled in the current lap
    assign w_cmt_id = {(o_new_cmt_id[`ROB_ENTRY_W-1:0] > `ROB_ENTRY_W'(e)) ?
                         o_new_cmt_id[`ROB_CMT_ID_W-1] : !o_new_cmt_id[`ROB_CMT_ID_W-1],
                       `ROB_ENTRY_W'(e)};

    rob_entry u_entry (
      .i_clk      (i_clk),
      .i_reset_n  (i_reset_n),
      .i_cmt_id   (w_cmt_id),
      .i_load     (w_load_oh[e]),
      .i_load_grp (w_load_grp),
      .i_done_rpt (i_done_rpt),
      .i_finish   (w_finish_oh[e]),
      .i_kill     (w_kill),
      .o_entry    (w_entries[e]),
      .o_all_done (w_all_done[e])
    );
  end

  rob_commit u_commit (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_entries   (w_entries),
    .i_all_done  (w_all_done),
    .i_in_ptr    (o_new_cmt_id),
    .o_finish_oh (w_finish_oh),
    .o_kill      (w_kill),
    .o_flush     (w_flush),
    .o_commit    (o_commit)
  );

endmodule

// ==== rtl/rob_commit.sv ====
`include "rob_consts.svh"

module rob_commit
  import rob_except_pkg::*;
  import rob_types_pkg::*;
(
  input  logic                        i_clk,
  input  logic                        i_reset_n,

  input  rob_entry_t                  i_entries [`ROB_ENTRY_SIZE],
  input  logic [`ROB_ENTRY_SIZE-1:0]  i_all_done,
  input  logic [`ROB_CMT_ID_W-1:0]    i_in_ptr,

  output logic [`ROB_ENTRY_SIZE-1:0]  o_finish_oh,
  output logic                        o_kill,
  output logic                        o_flush,
  output commit_blk_t                 o_commit
);

  localparam int LANE_W = $clog2(`ROB_DISP_SIZE);

  logic [`ROB_CMT_ID_W-1:0]  r_out_ptr;
  logic [`ROB_CMT_ID_W-1:0]  w_out_nxt;
  logic [`ROB_ENTRY_W-1:0]   w_out_idx;
  logic                      r_killing;  // Draining groups younger than a flush
  logic                      w_killing;
  rob_entry_t                w_head;
  logic                      w_live_cmt;
  logic                      w_commit;

  logic [`ROB_DISP_SIZE-1:0] w_redir_req;
  logic                      w_redir_valid;
  logic [`ROB_DISP_SIZE-1:0] w_redir_oh;
  logic                      w_redir_is_exc;
  logic [`ROB_DISP_SIZE-1:0] w_exc_oh;
  logic [LANE_W-1:0]         w_exc_idx;
  except_cause_t             w_exc_cause;
  logic [`ROB_VADDR_W-1:0]   w_br_target;
  logic [`ROB_VADDR_W-1:0]   w_epc;
  logic [`ROB_DISP_SIZE-1:0] w_above_redir;
  logic [`ROB_DISP_SIZE-1:0] w_dead_id;
  logic                      w_faulting;

  assign w_out_idx = r_out_ptr[`ROB_ENTRY_W-1:0];
  assign w_out_nxt = r_out_ptr + 1'b1;
  assign w_head    = i_entries[w_out_idx];

  assign w_killing  = r_killing & w_head.valid & w_head.dead;
  assign w_live_cmt = i_all_done[w_out_idx];
  assign w_commit   = w_live_cmt | w_killing;

  // First done lane that redirects the fetch
  assign w_redir_req = (w_head.except_valid | w_head.br_mispred) & w_head.done_grp_id;

  lsb_select #(.T(logic), .WORDS(`ROB_DISP_SIZE)) u_redir_sel (
    .i_req   (w_redir_req),
    .i_data  (w_head.except_valid),
    .o_valid (w_redir_valid),
    .o_oh    (w_redir_oh),
    .o_index (),
    .o_data  (w_redir_is_exc)
  );

  lsb_select #(.T(except_cause_t), .WORDS(`ROB_DISP_SIZE)) u_exc_sel (
    .i_req   (w_head.except_valid & w_redir_oh),
    .i_data  (w_head.except_cause),
    .o_valid (),
    .o_oh    (w_exc_oh),
    .o_index (w_exc_idx),
    .o_data  (w_exc_cause)
  );

  lsb_select #(.T(logic [`ROB_VADDR_W-1:0]), .WORDS(`ROB_DISP_SIZE)) u_br_sel (
    .i_req   (w_head.br_mispred & w_redir_oh),
    .i_data  (w_head.br_target),
    .o_valid (),
    .o_oh    (),
    .o_index (),
    .o_data  (w_br_target)
  );

  // Four bytes per lane
  assign w_epc = w_head.pc_addr + {{(`ROB_VADDR_W-LANE_W-2){1'b0}}, w_exc_idx, 2'b00};

  // Lanes strictly above the redirect lane, empty when none redirects
  assign w_above_redir = ~(w_redir_oh | (w_redir_oh - 1'b1));
  assign w_faulting    = w_redir_is_exc & !is_active_except(w_exc_cause);
  assign w_dead_id     = (w_above_redir | (w_faulting ? w_redir_oh : '0)) & w_head.grp_id;

  always_comb begin
    o_commit              = '0;
    o_commit.commit       = w_commit;
    o_commit.cmt_id       = r_out_ptr;
    o_commit.grp_id       = w_head.grp_id;
    o_commit.all_dead     = w_killing;
    if (w_killing) begin
      o_commit.dead_id      = w_head.grp_id;
    end else if (w_live_cmt) begin
      o_commit.upd_pc_valid = w_redir_valid;
      o_commit.upd_pc_vaddr = w_redir_is_exc ? w_epc : w_br_target;
      o_commit.except_valid = w_exc_oh;
      o_commit.except_cause = w_exc_cause;
      o_commit.epc          = w_epc;
      o_commit.dead_id      = w_dead_id;
    end
  end

  assign o_flush = w_live_cmt & w_redir_valid;
  assign o_kill  = o_flush;

  always_comb begin
    o_finish_oh = '0;
    o_finish_oh[w_out_idx] = w_commit;
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_out_ptr <= '0;
      r_killing <= 1'b0;
    end else begin
      if (w_commit) begin
        r_out_ptr <= w_out_nxt;
      end
      if (o_flush & (i_in_ptr != w_out_nxt)) begin
        r_killing <= 1'b1;
      end else if (r_killing & !w_killing) begin
        r_killing <= 1'b0;
      end
    end
  end

endmodule

// ==== rtl/rob_entry.sv ====
`include "rob_consts.svh"

module rob_entry
  import rob_except_pkg::*;
  import rob_types_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_reset_n,

  input  logic [`ROB_CMT_ID_W-1:0]  i_cmt_id,

  input  logic                      i_load,
  input  disp_grp_t                 i_load_grp,

  input  done_rpt_t                 i_done_rpt [`ROB_DONE_BUS],

  input  logic                      i_finish,
  input  logic                      i_kill,

  output rob_entry_t                o_entry,
  output logic                      o_all_done
);

  logic                                          r_valid;
  logic                                          r_dead;
  logic [`ROB_VADDR_W-1:0]                       r_pc_addr;
  logic [`ROB_DISP_SIZE-1:0]                     r_grp_id;
  logic [`ROB_DISP_SIZE-1:0]                     r_done_grp_id;
  logic [`ROB_DISP_SIZE-1:0]                     r_except_valid;
  except_cause_t [`ROB_DISP_SIZE-1:0]            r_except_cause;
  logic [`ROB_DISP_SIZE-1:0]                     r_br_mispred;
  logic [`ROB_DISP_SIZE-1:0][`ROB_VADDR_W-1:0]   r_br_target;

  logic [`ROB_DONE_BUS-1:0]  w_hit;
  logic [`ROB_DISP_SIZE-1:0] w_done_set;
  logic [`ROB_DISP_SIZE-1:0] w_except_set;
  logic [`ROB_DISP_SIZE-1:0] w_br_set;

  // Match reports from every bus against this entry's id
  always_comb begin
    w_done_set   = '0;
    w_except_set = '0;
    w_br_set     = '0;
    for (int b = 0; b < `ROB_DONE_BUS; b++) begin
      w_hit[b] = r_valid & i_done_rpt[b].valid & (i_done_rpt[b].cmt_id == i_cmt_id);
      if (w_hit[b]) begin
        w_done_set = w_done_set | i_done_rpt[b].grp_id;
        if (i_done_rpt[b].except_valid) begin
          w_except_set = w_except_set | i_done_rpt[b].grp_id;
        end
        if (i_done_rpt[b].br_mispred) begin
          w_br_set = w_br_set | i_done_rpt[b].grp_id;
        end
      end
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid        <= 1'b0;
      r_dead         <= 1'b0;
      r_done_grp_id  <= '0;
      r_except_valid <= '0;
      r_br_mispred   <= '0;
    end else if (i_load) begin
      r_valid        <= 1'b1;
      r_dead         <= 1'b0;
      r_done_grp_id  <= '0;
      r_except_valid <= '0;
      r_br_mispred   <= '0;
    end else if (i_finish) begin
      r_valid <= 1'b0;
      r_dead  <= 1'b0;
    end else begin
      // Head takes i_finish in the flush cycle, so only younger entries die
      if (i_kill & r_valid) begin
        r_dead <= 1'b1;
      end
      r_done_grp_id  <= r_done_grp_id  | w_done_set;
      r_except_valid <= r_except_valid | w_except_set;
      r_br_mispred   <= r_br_mispred   | w_br_set;
    end
  end

  // Group payload and per-lane results
  always_ff @(posedge i_clk) begin
    if (i_load) begin
      r_pc_addr <= i_load_grp.pc_addr;
      r_grp_id  <= i_load_grp.lane_valid;
    end
    for (int b = 0; b < `ROB_DONE_BUS; b++) begin
      for (int l = 0; l < `ROB_DISP_SIZE; l++) begin
        if (w_hit[b] & i_done_rpt[b].grp_id[l]) begin
          if (i_done_rpt[b].except_valid) begin
            r_except_cause[l] <= i_done_rpt[b].except_cause;
          end
          if (i_done_rpt[b].br_mispred) begin
            r_br_target[l] <= i_done_rpt[b].br_target;
          end
        end
      end
    end
  end

  always_comb begin
    o_entry.valid        = r_valid;
    o_entry.dead         = r_dead;
    o_entry.pc_addr      = r_pc_addr;
    o_entry.grp_id       = r_grp_id;
    o_entry.done_grp_id  = r_done_grp_id;
    o_entry.except_valid = r_except_valid;
    o_entry.except_cause = r_except_cause;
    o_entry.br_mispred   = r_br_mispred;
    o_entry.br_target    = r_br_target;
  end

  assign o_all_done = r_valid & !r_dead & (r_done_grp_id == r_grp_id);

endmodule

// ==== rtl/rob_disp_intake.sv ====
`include "rob_consts.svh"

module rob_disp_intake
  import rob_types_pkg::*;
(
  input  logic                        i_clk,
  input  logic                        i_reset_n,

  input  disp_grp_t                   i_disp,
  input  logic                        i_flush,
  input  logic                        i_commit,

  output logic [`ROB_ENTRY_SIZE-1:0]  o_load_oh,
  output disp_grp_t                   o_load_grp,
  output logic [`ROB_CMT_ID_W-1:0]    o_new_cmt_id,
  output credit_ret_t                 o_credit_ret
);

  logic [`ROB_CMT_ID_W-1:0] r_in_ptr;
  logic [`ROB_ENTRY_W-1:0]  w_in_idx;
  logic                     w_load;
  logic                     w_drop;
  logic [1:0]               w_ret_count;

  assign w_in_idx = r_in_ptr[`ROB_ENTRY_W-1:0];

  // A group arriving in the flush cycle would land behind the redirect
  assign w_load = i_disp.valid & !i_flush;
  assign w_drop = i_disp.valid & i_flush;

  always_comb begin
    o_load_oh = '0;
    for (int e = 0; e < `ROB_ENTRY_SIZE; e++) begin
      o_load_oh[e] = w_load & (w_in_idx == `ROB_ENTRY_W'(e));
    end
  end

  assign o_load_grp   = i_disp;
  assign o_new_cmt_id = r_in_ptr;

  // In-pointer, wrap bit rolls over naturally
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr <= '0;
    end else if (w_load) begin
      r_in_ptr <= r_in_ptr + 1'b1;
    end
  end

  // One credit per commit, one per dropped group
  assign w_ret_count = {1'b0, i_commit} + {1'b0, w_drop};

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_credit_ret <= '0;
    end else begin
      o_credit_ret.valid <= i_commit | w_drop;
      o_credit_ret.count <= w_ret_count;
    end
  end

endmodule

// ==== rtl/lsb_select.sv ====
module lsb_select #(
  parameter type T     = logic,
  parameter int  WORDS = 4
) (
  input  logic [WORDS-1:0]          i_req,
  input  T [WORDS-1:0]              i_data,
  output logic                      o_valid,
  output logic [WORDS-1:0]          o_oh,
  output logic [$clog2(WORDS)-1:0]  o_index,
  output T                          o_data
);

  localparam int IDX_W = $clog2(WORDS);

  logic [$bits(T)-1:0] w_acc;

  assign o_valid = |i_req;
  assign o_oh    = i_req & (~i_req + 1'b1);  // Isolate lowest set bit

  always_comb begin
    o_index = '0;
    w_acc   = '0;
    for (int i = 0; i < WORDS; i++) begin
      if (o_oh[i]) begin
        o_index = IDX_W'(i);
      end
      w_acc = w_acc | ({$bits(T){o_oh[i]}} & i_data[i]);
    end
  end

  assign o_data = T'(w_acc);

endmodule

// ==== rtl/rob_types_pkg.sv ====
`include "rob_consts.svh"

package rob_types_pkg;
  import rob_except_pkg::*;

  typedef struct packed {
    logic                          valid;
    logic [`ROB_VADDR_W-1:0]       pc_addr;      // Address of lane 0
    logic [`ROB_DISP_SIZE-1:0]     lane_valid;
    logic                          br_included;
  } disp_grp_t;

  typedef struct packed {
    logic                          valid;
    logic [`ROB_CMT_ID_W-1:0]      cmt_id;
    logic [`ROB_DISP_SIZE-1:0]     grp_id;       // One-hot lane
    logic                          except_valid;
    except_cause_t                 except_cause;
    logic                          br_mispred;
    logic [`ROB_VADDR_W-1:0]       br_target;
  } done_rpt_t;

  typedef struct packed {
    logic                                          valid;
    logic                                          dead;
    logic [`ROB_VADDR_W-1:0]                       pc_addr;
    logic [`ROB_DISP_SIZE-1:0]                     grp_id;
    logic [`ROB_DISP_SIZE-1:0]                     done_grp_id;
    logic [`ROB_DISP_SIZE-1:0]                     except_valid;
    except_cause_t [`ROB_DISP_SIZE-1:0]            except_cause;
    logic [`ROB_DISP_SIZE-1:0]                     br_mispred;
    logic [`ROB_DISP_SIZE-1:0][`ROB_VADDR_W-1:0]   br_target;
  } rob_entry_t;

  typedef struct packed {
    logic                          commit;
    logic [`ROB_CMT_ID_W-1:0]      cmt_id;
    logic [`ROB_DISP_SIZE-1:0]     grp_id;
    logic                          upd_pc_valid;
    logic [`ROB_VADDR_W-1:0]       upd_pc_vaddr;
    logic [`ROB_DISP_SIZE-1:0]     except_valid; // One-hot lane
    except_cause_t                 except_cause;
    logic [`ROB_VADDR_W-1:0]       epc;
    logic [`ROB_DISP_SIZE-1:0]     dead_id;
    logic                          all_dead;
  } commit_blk_t;

  typedef struct packed {
    logic       valid;
    logic [1:0] count;                           // 0 to 2
  } credit_ret_t;

endpackage

// ==== rtl/rob_except_pkg.sv ====
package rob_except_pkg;

  // Cause codes follow the RISC-V mcause numbering where one exists
  typedef enum logic [3:0] {
    INST_MISALIGN  = 4'd0,
    INST_ACC_FAULT = 4'd1,
    ILLEGAL_INST   = 4'd2,
    LOAD_FAULT     = 4'd5,
    STORE_FAULT    = 4'd7,
    ECALL_U        = 4'd8,
    ECALL_M        = 4'd11,
    MRET           = 4'd14,
    SILENT_FLUSH   = 4'd15
  } except_cause_t;

  // Causes where the reporting instruction itself still retires
  function automatic logic is_active_except(input except_cause_t cause);
    case (cause)
      ECALL_U, ECALL_M, MRET, SILENT_FLUSH: return 1'b1;
      default:                              return 1'b0;
    endcase
  endfunction

endpackage

// ==== rtl/rob_consts.svh ====
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// Lanes in one dispatch group
`define ROB_DISP_SIZE 4

// Reorder buffer depth, one group per entry
`define ROB_ENTRY_SIZE 8
`define ROB_ENTRY_W 3

// Entry index plus wrap bit
`define ROB_CMT_ID_W 4

// Completion buses feeding done reports
`define ROB_DONE_BUS 2

`define ROB_VADDR_W 32

`endif
